// ==== bench/frontEndTb.sv ====
`default_nettype none

module frontEndTb;
    import rv32Pkg::*;

    logic clk;
    logic rst;
    logic rdy;
    logic fetchEn;
    instWord_u fetchInst;
    logic [31:0] fetchPc;
    logic fetchPredTaken;
    logic commitEn;
    robTag_t commitTag;
    regName_t commitRd;
    logic [31:0] commitValue;
    dispatch_t dispatch;

    logic [31:0] lfsr;
    robTag_t expTag;
    logic mBusy [32];
    robTag_t mTag [32];
    logic [31:0] mReg [32];
    dispatch_t lastDisp;

    frontEnd frontEnd_i (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .fetchEn(fetchEn),
        .fetchInst(fetchInst),
        .fetchPc(fetchPc),
        .fetchPredTaken(fetchPredTaken),
        .commitEn(commitEn),
        .commitTag(commitTag),
        .commitRd(commitRd),
        .commitValue(commitValue),
        .dispatch(dispatch)
    );

    always #10 clk = ~clk;

    function logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1.
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function logic [31:0] encI(input logic [11:0] imm, input regName_t rs1,
                               input logic [2:0] f3, input regName_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function logic [31:0] encR(input logic [6:0] f7, input regName_t rs2, input regName_t rs1,
                               input logic [2:0] f3, input regName_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // reference decode straight from the ISA bit positions.
    function void decodeModel(input logic [31:0] w, output op_t op, output logic [31:0] imm,
                              output logic u1, output logic u2, output logic wr);
        logic [2:0] f3;
        logic b30;
        f3 = w[14:12];
        b30 = w[30];
        op = opNop;
        imm = '0;
        u1 = 1'b0;
        u2 = 1'b0;
        wr = 1'b0;
        case (w[6:0])
            7'b0110111: begin
                op = opLui;
                imm = {w[31:12], 12'b0};
                wr = 1'b1;
            end
            7'b0010111: begin
                op = opAuipc;
                imm = {w[31:12], 12'b0};
                wr = 1'b1;
            end
            7'b1101111: begin
                op = opJal;
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                wr = 1'b1;
            end
            7'b1100111: begin
                op = opJalr;
                imm = {{20{w[31]}}, w[31:20]};
                u1 = 1'b1;
                wr = 1'b1;
            end
            7'b1100011: begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                u1 = 1'b1;
                u2 = 1'b1;
                case (f3)
                    3'd0: op = opBeq;
                    3'd1: op = opBne;
                    3'd4: op = opBlt;
                    3'd5: op = opBge;
                    3'd6: op = opBltu;
                    3'd7: op = opBgeu;
                    default: op = opNop;
                endcase
            end
            7'b0000011: begin
                imm = {{20{w[31]}}, w[31:20]};
                u1 = 1'b1;
                wr = 1'b1;
                case (f3)
                    3'd0: op = opLb;
                    3'd1: op = opLh;
                    3'd2: op = opLw;
                    3'd4: op = opLbu;
                    3'd5: op = opLhu;
                    default: op = opNop;
                endcase
            end
            7'b0100011: begin
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
                u1 = 1'b1;
                u2 = 1'b1;
                case (f3)
                    3'd0: op = opSb;
                    3'd1: op = opSh;
                    3'd2: op = opSw;
                    default: op = opNop;
                endcase
            end
            7'b0010011: begin
                imm = {{20{w[31]}}, w[31:20]};
                u1 = 1'b1;
                wr = 1'b1;
                case (f3)
                    3'd0: op = opAddi;
                    3'd1: op = b30 ? opNop : opSlli;
                    3'd2: op = opSlti;
                    3'd3: op = opSltiu;
                    3'd4: op = opXori;
                    3'd5: op = b30 ? opSrai : opSrli;
                    3'd6: op = opOri;
                    default: op = opAndi;
                endcase
            end
            7'b0110011: begin
                u1 = 1'b1;
                u2 = 1'b1;
                wr = 1'b1;
                case (f3)
                    3'd0: op = b30 ? opSub : opAdd;
                    3'd1: op = b30 ? opNop : opSll;
                    3'd2: op = b30 ? opNop : opSlt;
                    3'd3: op = b30 ? opNop : opSltu;
                    3'd4: op = b30 ? opNop : opXor;
                    3'd5: op = b30 ? opSra : opSrl;
                    3'd6: op = b30 ? opNop : opOr;
                    default: op = b30 ? opNop : opAnd;
                endcase
            end
            default: op = opNop;
        endcase
        if (op == opNop) begin
            u1 = 1'b0;
            u2 = 1'b0;
            wr = 1'b0;
        end
        if (w[11:7] == 5'd0) begin
            wr = 1'b0;
        end
    endfunction

    task automatic reportFail(input string msg);
        $display("FAIL at time %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out after %0t while waiting for %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        expTag = '0;
        for (int i = 0; i < 32; i++) begin
            mBusy[i] = 1'b0;
            mTag[i] = '0;
            mReg[i] = '0;
        end
    endtask

    task automatic commitModel(input robTag_t tag, input regName_t rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            mReg[rd] = v;
        end
        if (mBusy[rd] && mTag[rd] == tag) begin
            mBusy[rd] = 1'b0;
        end
    endtask

    task automatic checkOperand(input operand_t got, input logic used, input regName_t rs,
                                input string name);
        operand_t e;
        e = '0;
        e.ready = 1'b1;
        if (used && rs != 5'd0) begin
            if (mBusy[rs]) begin
                e.ready = 1'b0;
                e.tag = mTag[rs];
            end else begin
                e.value = mReg[rs];
            end
        end
        assert (got == e) else reportFail($sformatf("%s of x%0d is %h, expected %h",
                                                    name, rs, got, e));
    endtask

    task automatic checkDispatch(input dispatch_t got, input logic [31:0] w,
                                 input logic [31:0] pc, input logic pred);
        op_t eop;
        logic [31:0] eimm;
        logic eu1;
        logic eu2;
        logic ewr;
        decodeModel(w, eop, eimm, eu1, eu2, ewr);
        assert (got.valid) else reportFail("dispatch not valid");
        assert (got.op == eop) else reportFail($sformatf("inst %h op %s, expected %s",
                                                         w, got.op.name(), eop.name()));
        assert (got.imm == eimm) else reportFail($sformatf("inst %h imm %h, expected %h",
                                                           w, got.imm, eimm));
        assert (got.rd == w[11:7] && got.writesRd == ewr)
            else reportFail($sformatf("inst %h rd or writesRd wrong", w));
        assert (got.pc == pc && got.predTaken == pred)
            else reportFail($sformatf("inst %h pc or predTaken wrong", w));
        assert (got.robTag == expTag) else reportFail($sformatf("robTag %0d, expected %0d",
                                                                got.robTag, expTag));
        checkOperand(got.src1, eu1, w[19:15], "src1");
        checkOperand(got.src2, eu2, w[24:20], "src2");
        if (ewr) begin
            mBusy[w[11:7]] = 1'b1;
            mTag[w[11:7]] = expTag;
        end
        expTag = expTag + 1'b1;
    endtask

    // sends one instruction and checks it comes out two edges later.
    task automatic fetchOne(input logic [31:0] w);
        logic [31:0] pc;
        logic pred;
        int n;
        pc = randBits(30) << 2;
        pred = randBits(1) != '0;
        @(posedge clk);
        fetchEn <= 1'b1;
        fetchInst <= w;
        fetchPc <= pc;
        fetchPredTaken <= pred;
        @(posedge clk);
        fetchEn <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!dispatch.valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!dispatch.valid) begin
            reportTimeout("dispatch.valid");
        end
        assert (n == 1) else reportFail($sformatf("latency off by %0d cycles", n - 1));
        lastDisp = dispatch;
        checkDispatch(dispatch, w, pc, pred);
    endtask

    task automatic commitOne(input robTag_t tag, input regName_t rd, input logic [31:0] v);
        @(posedge clk);
        commitEn <= 1'b1;
        commitTag <= tag;
        commitRd <= rd;
        commitValue <= v;
        @(posedge clk);
        commitEn <= 1'b0;
        commitModel(tag, rd, v);
    endtask

    task automatic testDecode();
        logic [6:0] opcs [12];
        logic [31:0] w;
        opcs = '{opcLui, opcAuipc, opcJal, opcJalr, opcBranch, opcLoad, opcStore,
                 opcOpImm, opcOp, 7'b1110011, 7'b0001111, 7'b0000000};
        foreach (opcs[k]) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int b = 0; b < 2; b++) begin
                    w = randBits(32);
                    w[6:0] = opcs[k];
                    w[14:12] = f3[2:0];
                    if (opcs[k] == opcOp || (opcs[k] == opcOpImm && (f3 == 1 || f3 == 5))) begin
                        w[31:25] = {1'b0, b[0], 5'b0};
                    end else begin
                        w[30] = b[0];
                    end
                    fetchOne(w);
                end
            end
        end
    endtask

    task automatic testStream();
        robTag_t start;
        start = expTag;
        for (int cyc = 0; cyc < 22; cyc++) begin
            @(posedge clk);
            if (cyc < 20) begin
                fetchEn <= 1'b1;
                fetchInst <= encI(cyc[11:0], 5'd0, 3'd0, 5'd0);
            end else begin
                fetchEn <= 1'b0;
            end
            @(negedge clk);
            if (cyc >= 2) begin
                assert (dispatch.valid && dispatch.imm == cyc - 2
                        && dispatch.robTag == robTag_t'(start + cyc - 2))
                    else reportFail($sformatf("stream slot %0d wrong, tag %0d",
                                              cyc - 2, dispatch.robTag));
            end else begin
                assert (!dispatch.valid) else reportFail("dispatch valid too early");
            end
        end
        expTag = robTag_t'(expTag + 5'd20); // wraps at 16.
    endtask

    task automatic testRename();
        robTag_t p;
        p = expTag;
        fetchOne(encI(12'h011, 5'd0, 3'd0, 5'd5));
        fetchOne(encR(7'h00, 5'd0, 5'd5, 3'd0, 5'd6));
        assert (!lastDisp.src1.ready && lastDisp.src1.tag == p)
            else reportFail("consumer did not wait on producer tag");
        fetchOne(encI(12'h7ff, 5'd0, 3'd0, 5'd0));
        fetchOne(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd7));
        assert (lastDisp.src1.ready && lastDisp.src1.value == 0)
            else reportFail("x0 source not ready zero");
    endtask

    task automatic testCommit();
        robTag_t p1;
        robTag_t p2;
        logic [31:0] w;
        p1 = expTag;
        fetchOne(encI(12'h001, 5'd0, 3'd0, 5'd9));
        commitOne(p1, 5'd9, 32'hcafe0009);
        fetchOne(encI(12'h000, 5'd9, 3'd0, 5'd0));
        assert (lastDisp.src1.ready && lastDisp.src1.value == 32'hcafe0009)
            else reportFail("committed value not read back");
        // commit lands on the edge where the reader renames.
        p1 = expTag;
        fetchOne(encI(12'h002, 5'd0, 3'd0, 5'd10));
        w = encR(7'h00, 5'd0, 5'd10, 3'd0, 5'd0);
        @(posedge clk);
        fetchEn <= 1'b1;
        fetchInst <= w;
        fetchPc <= 32'h100;
        fetchPredTaken <= 1'b0;
        @(posedge clk);
        fetchEn <= 1'b0;
        commitEn <= 1'b1;
        commitTag <= p1;
        commitRd <= 5'd10;
        commitValue <= 32'h0bad0010;
        @(posedge clk);
        commitEn <= 1'b0;
        commitModel(p1, 5'd10, 32'h0bad0010);
        @(negedge clk);
        assert (dispatch.src1.ready && dispatch.src1.value == 32'h0bad0010)
            else reportFail("same-cycle commit not forwarded");
        checkDispatch(dispatch, w, 32'h100, 1'b0);
        p1 = expTag;
        fetchOne(encI(12'h003, 5'd0, 3'd0, 5'd12));
        p2 = expTag;
        fetchOne(encI(12'h004, 5'd0, 3'd0, 5'd12));
        commitOne(p1, 5'd12, 32'h11111111);
        fetchOne(encI(12'h000, 5'd12, 3'd0, 5'd0));
        assert (!lastDisp.src1.ready && lastDisp.src1.tag == p2)
            else reportFail("stale commit cleared the newer busy mark");
        commitOne(p2, 5'd12, 32'h22222222);
        fetchOne(encI(12'h000, 5'd12, 3'd0, 5'd0));
        assert (lastDisp.src1.ready && lastDisp.src1.value == 32'h22222222)
            else reportFail("newest commit not visible");
    endtask

    task automatic testStall();
        robTag_t t;
        robTag_t p;
        p = expTag;
        fetchOne(encI(12'h005, 5'd0, 3'd0, 5'd13));
        t = expTag;
        @(posedge clk);
        fetchEn <= 1'b1;
        fetchInst <= encI(12'h0a1, 5'd13, 3'd0, 5'd0);
        @(posedge clk);
        fetchInst <= {20'h12345, 5'd0, 7'b0110111};
        @(posedge clk);
        fetchEn <= 1'b0;
        rdy <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (dispatch.valid && dispatch.op == opAddi && dispatch.robTag == t
                    && !dispatch.src1.ready && dispatch.src1.tag == p)
                else reportFail($sformatf("held packet changed in stall cycle %0d", i));
        end
        // producer commits while the consumer is held.
        @(posedge clk);
        commitEn <= 1'b1;
        commitTag <= p;
        commitRd <= 5'd13;
        commitValue <= 32'h5a5a0013;
        @(posedge clk);
        commitEn <= 1'b0;
        rdy <= 1'b1;
        commitModel(p, 5'd13, 32'h5a5a0013);
        @(negedge clk);
        assert (dispatch.valid && dispatch.op == opAddi && dispatch.robTag == t
                && dispatch.src1.ready && dispatch.src1.tag == '0
                && dispatch.src1.value == 32'h5a5a0013)
            else reportFail("held operand not woken by commit");
        @(posedge clk);
        @(negedge clk);
        assert (dispatch.valid && dispatch.op == opLui && dispatch.robTag == robTag_t'(t + 1))
            else reportFail("second instruction wrong after stall");
        @(negedge clk);
        assert (!dispatch.valid) else reportFail("extra dispatch after stall");
        expTag = expTag + 2'd2;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        fetchInst = '0;
        fetchPc = '0;
        fetchPredTaken = 1'b0;
        commitEn = 1'b0;
        commitTag = '0;
        commitRd = '0;
        commitValue = '0;
        lfsr = 32'h6388;
        applyReset();
        testDecode();
        applyReset();
        testStream();
        testRename();
        testCommit();
        testStall();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/frontEnd_properties.sv ====
`default_nettype none

module frontEnd_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic rdy,
    input wire logic commitEn,
    input wire rv32Pkg::dispatch_t dispatch
);
    import rv32Pkg::*;

    // first edge out of reset sees an empty dispatch register.
    noDispatchAfterReset: assert property (@(posedge clk) $fell(rst) |-> !dispatch.valid)
        else $error("dispatch valid right after reset");

    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        (!rdy && !commitEn) |=> $stable(dispatch))
        else $error("dispatch changed during a stall without commit");

    readySrc1ZeroTag: assert property (@(posedge clk) disable iff (rst)
        dispatch.src1.ready |-> dispatch.src1.tag == '0)
        else $error("ready src1 carries a tag");

    readySrc2ZeroTag: assert property (@(posedge clk) disable iff (rst)
        dispatch.src2.ready |-> dispatch.src2.tag == '0)
        else $error("ready src2 carries a tag");

endmodule

bind frontEnd frontEnd_properties props (
    .clk(clk),
    .rst(rst),
    .rdy(rdy),
    .commitEn(commitEn),
    .dispatch(dispatch)
);

`default_nettype wire

// ==== frontEnd.f ====
logic/rv32Pkg.sv
logic/instDecoder.sv
logic/operandRename.sv
logic/frontEnd.sv
bench/frontEnd_properties.sv
bench/frontEndTb.sv

// ==== logic/frontEnd.sv ====
`default_nettype none

module frontEnd (
    input wire logic clk,
    input wire logic rst,
    input wire logic rdy,
    input wire logic fetchEn,
    input wire rv32Pkg::instWord_u fetchInst,
    input wire logic [rv32Pkg::xlen-1:0] fetchPc,
    input wire logic fetchPredTaken,
    input wire logic commitEn,
    input wire rv32Pkg::robTag_t commitTag,
    input wire rv32Pkg::regName_t commitRd,
    input wire logic [rv32Pkg::xlen-1:0] commitValue,
    output rv32Pkg::dispatch_t dispatch
);
    import rv32Pkg::*;

    decoded_t decoded;

    instDecoder decodeStage (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .fetchEn(fetchEn),
        .fetchInst(fetchInst),
        .fetchPc(fetchPc),
        .fetchPredTaken(fetchPredTaken),
        .decoded(decoded)
    );

    // commit bypasses decode and goes straight to rename.
    operandRename renameStage (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .decoded(decoded),
        .commitEn(commitEn),
        .commitTag(commitTag),
        .commitRd(commitRd),
        .commitValue(commitValue),
        .dispatch(dispatch)
    );

endmodule

`default_nettype wire

// ==== logic/instDecoder.sv ====
`default_nettype none

module instDecoder (
    input wire logic clk,
    input wire logic rst,
    input wire logic rdy,
    input wire logic fetchEn,
    input wire rv32Pkg::instWord_u fetchInst,
    input wire logic [rv32Pkg::xlen-1:0] fetchPc,
    input wire logic fetchPredTaken,
    output rv32Pkg::decoded_t decoded
);
    import rv32Pkg::*;

    logic [3:0] funct;
    logic [xlen-1:0] uImm;
    logic [xlen-1:0] jImm;
    logic [xlen-1:0] bImm;
    logic [xlen-1:0] iImm;
    logic [xlen-1:0] sImm;
    op_t op;
    logic [xlen-1:0] imm;
    logic usesRs1;
    logic usesRs2;
    logic writesRd;
    decoded_t nextDec;

    assign funct = {fetchInst.rType.funct7[5], fetchInst.rType.funct3}; // bit 30 splits sub/sra.

    // same word seen through each format.
    assign uImm = {fetchInst.uType.imm31to12, 12'b0};
    assign jImm = {{12{fetchInst.jType.imm20}}, fetchInst.jType.imm19to12,
                   fetchInst.jType.imm11, fetchInst.jType.imm10to1, 1'b0};
    assign bImm = {{20{fetchInst.bType.imm12}}, fetchInst.bType.imm11,
                   fetchInst.bType.imm10to5, fetchInst.bType.imm4to1, 1'b0};
    assign iImm = {{20{fetchInst.iType.imm11to0[11]}}, fetchInst.iType.imm11to0};
    assign sImm = {{20{fetchInst.sType.immHi[6]}}, fetchInst.sType.immHi, fetchInst.sType.immLo};

    always_comb begin
        op = opNop;
        imm = '0;
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;
        writesRd = 1'b0;
        case (fetchInst.rType.opcode)
            opcLui: begin
                op = opLui;
                imm = uImm;
                writesRd = 1'b1;
            end
            opcAuipc: begin
                op = opAuipc;
                imm = uImm;
                writesRd = 1'b1;
            end
            opcJal: begin
                op = opJal;
                imm = jImm;
                writesRd = 1'b1;
            end
            opcJalr: begin
                op = opJalr;
                imm = iImm;
                usesRs1 = 1'b1;
                writesRd = 1'b1;
            end
            opcBranch: begin
                imm = bImm;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (fetchInst.bType.funct3)
                    3'b000: op = opBeq;
                    3'b001: op = opBne;
                    3'b100: op = opBlt;
                    3'b101: op = opBge;
                    3'b110: op = opBltu;
                    3'b111: op = opBgeu;
                    default: op = opNop;
                endcase
            end
            opcLoad: begin
                imm = iImm;
                usesRs1 = 1'b1;
                writesRd = 1'b1;
                case (fetchInst.iType.funct3)
                    3'b000: op = opLb;
                    3'b001: op = opLh;
                    3'b010: op = opLw;
                    3'b100: op = opLbu;
                    3'b101: op = opLhu;
                    default: op = opNop;
                endcase
            end
            opcStore: begin
                imm = sImm;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (fetchInst.sType.funct3)
                    3'b000: op = opSb;
                    3'b001: op = opSh;
                    3'b010: op = opSw;
                    default: op = opNop;
                endcase
            end
            opcOpImm: begin
                imm = iImm;
                usesRs1 = 1'b1;
                writesRd = 1'b1;
                case (funct)
                    4'b0000, 4'b1000: op = opAddi;
                    4'b0010, 4'b1010: op = opSlti;
                    4'b0011, 4'b1011: op = opSltiu;
                    4'b0100, 4'b1100: op = opXori;
                    4'b0110, 4'b1110: op = opOri;
                    4'b0111, 4'b1111: op = opAndi;
                    4'b0001: op = opSlli;
                    4'b0101: op = opSrli;
                    4'b1101: op = opSrai;
                    default: op = opNop; // slli with bit 30 set.
                endcase
            end
            opcOp: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                writesRd = 1'b1;
                case (funct)
                    4'b0000: op = opAdd;
                    4'b1000: op = opSub;
                    4'b0001: op = opSll;
                    4'b0010: op = opSlt;
                    4'b0011: op = opSltu;
                    4'b0100: op = opXor;
                    4'b0101: op = opSrl;
                    4'b1101: op = opSra;
                    4'b0110: op = opOr;
                    4'b0111: op = opAnd;
                    default: op = opNop;
                endcase
            end
            default: op = opNop;
        endcase
        // a nop reads and writes nothing, whatever its format.
        if (op == opNop) begin
            usesRs1 = 1'b0;
            usesRs2 = 1'b0;
            writesRd = 1'b0;
        end
        if (fetchInst.rType.rd == 5'd0) begin
            writesRd = 1'b0;
        end
    end

    always_comb begin
        nextDec.valid = fetchEn;
        nextDec.op = op;
        nextDec.rs1 = fetchInst.rType.rs1;
        nextDec.rs2 = fetchInst.rType.rs2;
        nextDec.rd = fetchInst.rType.rd;
        nextDec.usesRs1 = usesRs1;
        nextDec.usesRs2 = usesRs2;
        nextDec.writesRd = writesRd;
        nextDec.imm = imm;
        nextDec.pc = fetchPc;
        nextDec.predTaken = fetchPredTaken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded.valid <= 1'b0;
        end else if (rdy) begin
            decoded <= nextDec; // holds while stalled.
        end
    end

endmodule

`default_nettype wire

// ==== logic/operandRename.sv ====
`default_nettype none

module operandRename (
    input wire logic clk,
    input wire logic rst,
    input wire logic rdy,
    input wire rv32Pkg::decoded_t decoded,
    input wire logic commitEn,
    input wire rv32Pkg::robTag_t commitTag,
    input wire rv32Pkg::regName_t commitRd,
    input wire logic [rv32Pkg::xlen-1:0] commitValue,
    output rv32Pkg::dispatch_t dispatch
);
    import rv32Pkg::*;

    logic [xlen-1:0] regFile [32];
    logic [31:0] busy;
    robTag_t tagTable [32];
    robTag_t tagCounter;
    dispatch_t nextDispatch;

    // busy entry waiting on a tag that is not committing now gives the tag.
    function automatic operand_t readOperand(input logic used, input regName_t name);
        operand_t o;
        logic tagHit;
        o = '0;
        o.ready = 1'b1;
        tagHit = commitEn && (tagTable[name] == commitTag);
        if (used && name != 5'd0) begin
            if (busy[name] && !tagHit) begin
                o.ready = 1'b0;
                o.tag = tagTable[name];
            end else if ((busy[name] && tagHit) || (commitEn && commitRd == name)) begin
                o.value = commitValue; // bypass of this cycle's commit.
            end else begin
                o.value = regFile[name];
            end
        end
        return o;
    endfunction

    // wakes a held operand when its producer commits.
    function automatic operand_t wakeOperand(input operand_t o);
        operand_t w;
        w = o;
        if (!o.ready && o.tag == commitTag) begin
            w.ready = 1'b1;
            w.tag = '0;
            w.value = commitValue;
        end
        return w;
    endfunction

    always_comb begin
        nextDispatch.valid = decoded.valid;
        nextDispatch.op = decoded.op;
        nextDispatch.src1 = readOperand(decoded.usesRs1, decoded.rs1);
        nextDispatch.src2 = readOperand(decoded.usesRs2, decoded.rs2);
        nextDispatch.rd = decoded.rd;
        nextDispatch.writesRd = decoded.writesRd;
        nextDispatch.robTag = tagCounter;
        nextDispatch.imm = decoded.imm;
        nextDispatch.pc = decoded.pc;
        nextDispatch.predTaken = decoded.predTaken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (commitEn && commitRd != 5'd0) begin
            regFile[commitRd] <= commitValue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            tagCounter <= '0;
        end else begin
            if (commitEn && busy[commitRd] && tagTable[commitRd] == commitTag) begin
                busy[commitRd] <= 1'b0; // stale tags leave the newer mark.
            end
            if (rdy && decoded.valid) begin
                tagCounter <= tagCounter + 1'b1; // wraps at 16.
                if (decoded.writesRd) begin
                    busy[decoded.rd] <= 1'b1; // later assignment beats the clear.
                    tagTable[decoded.rd] <= tagCounter;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch.valid <= 1'b0;
        end else if (rdy) begin
            dispatch <= nextDispatch;
        end else if (commitEn) begin
            dispatch.src1 <= wakeOperand(dispatch.src1);
            dispatch.src2 <= wakeOperand(dispatch.src2);
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv32Pkg.sv ====
`default_nettype none

package rv32Pkg;

    localparam int xlen = 32;
    localparam int robTagW = 4; // 16 tags in flight.

    typedef logic [4:0] regName_t;
    typedef logic [robTagW-1:0] robTag_t;

    localparam logic [6:0] opcLui = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;
    localparam logic [6:0] opcJal = 7'b1101111;
    localparam logic [6:0] opcJalr = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad = 7'b0000011;
    localparam logic [6:0] opcStore = 7'b0100011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcOp = 7'b0110011;

    typedef enum logic [5:0] {
        opNop, opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd
    } op_t;

    typedef struct packed {
        logic [6:0] funct7;
        regName_t rs2;
        regName_t rs1;
        logic [2:0] funct3;
        regName_t rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm11to0;
        regName_t rs1;
        logic [2:0] funct3;
        regName_t rd;
        logic [6:0] opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        regName_t rs2;
        regName_t rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10to5;
        regName_t rs2;
        regName_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm31to12;
        regName_t rd;
        logic [6:0] opcode;
    } uType_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10to1;
        logic imm11;
        logic [7:0] imm19to12;
        regName_t rd;
        logic [6:0] opcode;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } instWord_u;

    typedef struct packed {
        logic valid;
        op_t op;
        regName_t rs1;
        regName_t rs2;
        regName_t rd;
        logic usesRs1;
        logic usesRs2;
        logic writesRd;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        logic predTaken;
    } decoded_t;

    typedef struct packed {
        logic ready;
        robTag_t tag; // names the producer and reads zero when ready.
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        logic valid;
        op_t op;
        operand_t src1;
        operand_t src2;
        regName_t rd;
        logic writesRd;
        robTag_t robTag;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        logic predTaken;
    } dispatch_t;

endpackage

`default_nettype wire
